// ==== files.f ====
logic/icache_pkg.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_refill.sv
logic/icache_ctrl.sv
logic/icache_top.sv
sim/icache_mem_model.sv
sim/icache_checker.sv
sim/icache_tb.sv

// ==== logic/icache_ctrl.sv ====
// icache access fsm, index and tag select, replacement lfsr, cpu response
`timescale 1ns/1ps

module icache_ctrl
  import icache_pkg::*;
#(
  parameter int NUM_WAYS = 2,
  parameter int NUM_SETS = 16,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - IDX_W - LINE_OFF_W - WORD_OFF_W,
  localparam int WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1
)
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  cpu_req_t              cpu_req_i,
  output cpu_rsp_t              cpu_rsp_o,
  input  logic                  flush_i,
  input  logic [NUM_WAYS-1:0]   hit_i,
  input  logic [DATA_W-1:0]     word_i,
  output logic [IDX_W-1:0]      rd_idx_o,
  output logic [TAG_W-1:0]      tag_o,        // compare tag, fill tag in FILL
  output logic [NUM_WAYS-1:0]   wr_way_o,
  output logic [IDX_W-1:0]      wr_idx_o,
  output logic                  flush_clr_o,
  output refill_cmd_e           cmd_o,
  output logic [ADDR_W-1:0]     line_adr_o,
  input  logic                  beat_i,
  input  logic [DATA_W-1:0]     beat_data_i,
  input  logic [LINE_OFF_W-1:0] beat_off_i,
  input  logic                  done_i,
  input  logic                  fill_err_i
);

  access_state_e           state_q;
  logic                    req_q;         // lookup result for a live request
  logic                    flush_pend_q;
  logic                    crit_wait_q;   // cpu still waits on this fill
  logic [ADDR_W-1:WORD_OFF_W] addr_q;
  logic [IDX_W-1:0]        miss_idx_q;
  logic [TAG_W-1:0]        miss_tag_q;
  logic [LINE_OFF_W-1:0]   miss_off_q;
  logic [19:0]             lfsr_q;
  logic [NUM_WAYS-1:0]     way_pick;
  logic [NUM_WAYS-1:0]     fill_way_q;
  logic [IDX_W-1:0]        cpu_idx;
  logic [TAG_W-1:0]        cpu_tag;
  logic                    flush_go;
  logic                    miss;
  logic                    hit_ack;
  logic                    crit_ack;

  assign cpu_idx = cpu_req_i.addr[WORD_OFF_W+LINE_OFF_W +: IDX_W];
  assign cpu_tag = cpu_req_i.addr[ADDR_W-1 -: TAG_W];

  assign flush_go = flush_i | flush_pend_q;
  assign miss     = (state_q == ARMED) & req_q & ~|hit_i & ~flush_go;  // flush wins
  assign hit_ack  = (state_q == ARMED) & req_q & |hit_i;
  assign crit_ack = (state_q == FILL) & crit_wait_q & beat_i & (beat_off_i == miss_off_q);

  // ----------------------------------------------------------
  // access fsm
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ARMED;
      cmd_o   <= NOP;
    end
    else
    begin
      unique case (state_q)
        ARMED:
        begin
          if (flush_go)
          begin
            state_q <= FLUSH;
          end
          else if (miss)
          begin
            state_q <= FILL;
            cmd_o   <= READ_LINE;  // stb next cycle
          end
        end
        FILL:
        begin
          if (done_i || fill_err_i)
          begin
            state_q <= RECOVER;
            cmd_o   <= NOP;
          end
        end
        FLUSH:   state_q <= RECOVER;
        RECOVER: state_q <= ARMED;   // tags re-read for a held request
        default: state_q <= ARMED;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      req_q        <= 1'b0;
      flush_pend_q <= 1'b0;
      crit_wait_q  <= 1'b0;
    end
    else
    begin
      req_q        <= cpu_req_i.valid & ~cpu_rsp_o.ack & ~cpu_rsp_o.err;
      flush_pend_q <= flush_go & (state_q != FLUSH);  // kept across a fill
      if (miss)
      begin
        crit_wait_q <= 1'b1;
      end
      else if (cpu_rsp_o.ack || cpu_rsp_o.err)
      begin
        crit_wait_q <= 1'b0;
      end
    end
  end

  // registered request, aligned with the array outputs
  always_ff @(posedge clk_i)
  begin
    addr_q <= cpu_req_i.addr[ADDR_W-1:WORD_OFF_W];
  end

  // miss line and victim way, frozen for the fill
  always_ff @(posedge clk_i)
  begin
    if (miss)
    begin
      miss_idx_q <= addr_q[WORD_OFF_W+LINE_OFF_W +: IDX_W];
      miss_tag_q <= addr_q[ADDR_W-1 -: TAG_W];
      miss_off_q <= addr_q[WORD_OFF_W +: LINE_OFF_W];
      fill_way_q <= way_pick;
    end
  end

  // ----------------------------------------------------------
  // random replacement
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      lfsr_q <= '0;  // xnor taps, zero is a legal state
    end
    else if (state_q != FILL)
    begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ~^ lfsr_q[16]};
    end
  end

  // NUM_WAYS power of two
  assign way_pick = (NUM_WAYS == 1) ? '1 : NUM_WAYS'(1) << lfsr_q[WAY_W-1:0];

  // ----------------------------------------------------------
  // array control
  // ----------------------------------------------------------
  always_comb
  begin
    unique case (state_q)
      FILL:
      begin
        rd_idx_o = miss_idx_q;
        tag_o    = miss_tag_q;  // tag write on done
      end
      default:
      begin
        rd_idx_o = cpu_idx;     // lookup for the presented address
        tag_o    = cpu_tag;
      end
    endcase
  end

  // errored line never written, stays invalid
  assign wr_way_o    = ((state_q == FILL) && done_i) ? fill_way_q : '0;
  assign wr_idx_o    = miss_idx_q;
  assign flush_clr_o = (state_q == FLUSH);
  assign line_adr_o  = {miss_tag_q, miss_idx_q, miss_off_q, {WORD_OFF_W{1'b0}}};

  // cpu response, fill path forwards the critical beat
  assign cpu_rsp_o.ack  = hit_ack | crit_ack;
  assign cpu_rsp_o.err  = (state_q == FILL) & crit_wait_q & fill_err_i;
  assign cpu_rsp_o.data = (state_q == FILL) ? beat_data_i : word_i;

endmodule

// ==== logic/icache_data_array.sv ====
// icache line memories per way, and-or hit mux and word select
`timescale 1ns/1ps

module icache_data_array
  import icache_pkg::*;
#(
  parameter int NUM_WAYS = 2,
  parameter int NUM_SETS = 16,
  localparam int IDX_W = $clog2(NUM_SETS)
)
(
  input  logic                  clk_i,
  input  logic [IDX_W-1:0]      rd_idx_i,
  input  logic [NUM_WAYS-1:0]   wr_way_i,    // one-hot, whole line at once
  input  logic [IDX_W-1:0]      wr_idx_i,
  input  line_t                 wr_line_i,
  input  logic [NUM_WAYS-1:0]   hit_i,       // from tag array, already aligned
  input  logic [LINE_OFF_W-1:0] word_sel_i,  // word of the current request
  output logic [DATA_W-1:0]     word_o
);

  localparam int LINE_BITS = $bits(line_t);

  line_t                 rd_line [NUM_WAYS];
  line_t                 sel_line;
  logic [LINE_OFF_W-1:0] word_sel_q;

  for (genvar w = 0; w < NUM_WAYS; w++)
  begin : g_way
    line_t line_mem [NUM_SETS];

    always_ff @(posedge clk_i)
    begin
      if (wr_way_i[w])
      begin
        line_mem[wr_idx_i] <= wr_line_i;
      end
      rd_line[w] <= line_mem[rd_idx_i];
    end
  end

  // follows the ram read by one cycle
  always_ff @(posedge clk_i)
  begin
    word_sel_q <= word_sel_i;
  end

  // and-or mux, hit is one-hot or zero
  always_comb
  begin
    sel_line = '0;
    for (int w = 0; w < NUM_WAYS; w++)
    begin
      sel_line = sel_line | (rd_line[w] & {LINE_BITS{hit_i[w]}});
    end
  end

  assign word_o = sel_line[word_sel_q];

endmodule

// ==== logic/icache_pkg.sv ====
// icache shared widths, cpu and memory bus structs, state and command enums
package icache_pkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int LINE_WORDS = 4;   // words per line, also beats per burst
  localparam int WORD_OFF_W = 2;   // byte offset inside a word
  localparam int LINE_OFF_W = 2;   // word offset inside a line

  // one cache line, word 0 in the low bits
  typedef logic [LINE_WORDS-1:0][DATA_W-1:0] line_t;

  // ----------------------------------------------------------
  // cpu fetch port
  // ----------------------------------------------------------
  typedef struct packed {
    logic              valid;  // held until ack or err
    logic [ADDR_W-1:0] addr;
  } cpu_req_t;

  typedef struct packed {
    logic              ack;   // single cycle
    logic              err;   // single cycle, no data
    logic [DATA_W-1:0] data;  // valid with ack only
  } cpu_rsp_t;

  // ----------------------------------------------------------
  // memory burst port
  // ----------------------------------------------------------
  typedef struct packed {
    logic              stb;  // held until stb_ack
    logic [ADDR_W-1:0] adr;  // word aligned, first beat of the wrap
  } mem_req_t;

  typedef struct packed {
    logic              stb_ack;  // burst accepted
    logic              ack;      // one per beat
    logic              err;      // aborts the burst
    logic [ADDR_W-1:0] adr;      // address of the returned beat
    logic [DATA_W-1:0] data;
  } mem_rsp_t;

  // access fsm
  typedef enum logic [1:0] {ARMED, FILL, FLUSH, RECOVER} access_state_e;

  // bus fsm
  typedef enum logic [1:0] {IDLE, WAIT4BUS, BURST} bus_state_e;

  // ctrl -> refill
  typedef enum logic {NOP, READ_LINE} refill_cmd_e;

endpackage

// ==== logic/icache_refill.sv ====
// icache bus fsm, beat counter and line assembly buffer
`timescale 1ns/1ps

module icache_refill
  import icache_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  refill_cmd_e           cmd_i,
  input  logic [ADDR_W-1:0]     line_adr_i,   // word aligned, critical word
  output mem_req_t              mem_req_o,
  input  mem_rsp_t              mem_rsp_i,
  output logic                  beat_o,       // good beat this cycle
  output logic [DATA_W-1:0]     beat_data_o,
  output logic [LINE_OFF_W-1:0] beat_off_o,
  output line_t                 line_o,       // complete on done_o
  output logic                  done_o,
  output logic                  err_o
);

  localparam logic [LINE_OFF_W-1:0] LAST_BEAT = LINE_OFF_W'(LINE_WORDS - 1);

  bus_state_e            state_q;
  logic [LINE_OFF_W-1:0] cnt_q;    // beats still to come, minus one
  logic [ADDR_W-1:0]     adr_q;    // holds adr while stb waits
  line_t                 line_q;
  logic [LINE_OFF_W-1:0] off;

  assign off = mem_rsp_i.adr[WORD_OFF_W +: LINE_OFF_W];  // wrap position

  assign beat_o      = (state_q == BURST) & mem_rsp_i.ack & ~mem_rsp_i.err;
  assign beat_data_o = mem_rsp_i.data;
  assign beat_off_o  = off;
  assign done_o      = beat_o & (cnt_q == '0);
  assign err_o       = (state_q == BURST) & mem_rsp_i.err;  // ends burst at once

  // ----------------------------------------------------------
  // bus fsm
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= IDLE;
      cnt_q   <= LAST_BEAT;
    end
    else
    begin
      unique case (state_q)
        IDLE:
        begin
          cnt_q <= LAST_BEAT;
          if (cmd_i == READ_LINE)
          begin
            // stb is already out this cycle
            state_q <= mem_rsp_i.stb_ack ? BURST : WAIT4BUS;
          end
        end
        WAIT4BUS:
        begin
          cnt_q <= LAST_BEAT;
          if (mem_rsp_i.stb_ack)
          begin
            state_q <= BURST;
          end
        end
        BURST:
        begin
          if (err_o || done_o)
          begin
            state_q <= IDLE;
          end
          else if (beat_o)
          begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // strobe straight from the command, no extra cycle
  always_comb
  begin
    mem_req_o.stb = (state_q == WAIT4BUS) || ((state_q == IDLE) && (cmd_i == READ_LINE));
    mem_req_o.adr = (state_q == IDLE) ? line_adr_i : adr_q;
  end

  always_ff @(posedge clk_i)
  begin
    if (state_q == IDLE)
    begin
      adr_q <= line_adr_i;
    end
  end

  // ----------------------------------------------------------
  // line assembly
  // ----------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (beat_o)
    begin
      line_q[off] <= mem_rsp_i.data;
    end
  end

  // last beat merged in here so the line is written on done
  always_comb
  begin
    line_o      = line_q;
    line_o[off] = mem_rsp_i.data;
  end

endmodule

// ==== logic/icache_tag_array.sv ====
// icache tag memories per way, valid flops and way hit compare
`timescale 1ns/1ps

module icache_tag_array
  import icache_pkg::*;
#(
  parameter int NUM_WAYS = 2,
  parameter int NUM_SETS = 16,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - IDX_W - LINE_OFF_W - WORD_OFF_W
)
(
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic [IDX_W-1:0]    rd_idx_i,   // set to look up
  input  logic [NUM_WAYS-1:0] wr_way_i,   // one-hot fill way
  input  logic [IDX_W-1:0]    wr_idx_i,
  input  logic [TAG_W-1:0]    wr_tag_i,
  input  logic                flush_i,    // clears every valid bit
  input  logic [TAG_W-1:0]    cmp_tag_i,  // tag of the current request
  output logic [NUM_WAYS-1:0] hit_o
);

  logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
  logic [TAG_W-1:0]                  tag_rd [NUM_WAYS];
  logic [IDX_W-1:0]                  rd_idx_q;   // lines up valid with the ram read
  logic [TAG_W-1:0]                  cmp_tag_q;

  // ----------------------------------------------------------
  // tag rams, one per way
  // ----------------------------------------------------------
  for (genvar w = 0; w < NUM_WAYS; w++)
  begin : g_way
    logic [TAG_W-1:0] tag_mem [NUM_SETS];

    always_ff @(posedge clk_i)
    begin
      if (wr_way_i[w])
      begin
        tag_mem[wr_idx_i] <= wr_tag_i;
      end
      tag_rd[w] <= tag_mem[rd_idx_i];  // read before write on same set
    end

    // stored tag vs registered request tag
    assign hit_o[w] = valid_q[w][rd_idx_q] & (tag_rd[w] == cmp_tag_q);
  end

  // request side, same cycle as the ram read
  always_ff @(posedge clk_i)
  begin
    rd_idx_q  <= rd_idx_i;
    cmp_tag_q <= cmp_tag_i;
  end

  // ----------------------------------------------------------
  // valid bits in flops so flush is a single cycle
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
    end
    else if (flush_i)
    begin
      valid_q <= '0;
    end
    else
    begin
      for (int w = 0; w < NUM_WAYS; w++)
      begin
        if (wr_way_i[w])
        begin
          valid_q[w][wr_idx_i] <= 1'b1;  // only complete lines get here
        end
      end
    end
  end

endmodule

// ==== logic/icache_top.sv ====
// icache top level, ctrl, tag array, data array and refill wired together
`timescale 1ns/1ps

module icache_top
  import icache_pkg::*;
#(
  parameter int NUM_WAYS = 2,
  parameter int NUM_SETS = 16,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - IDX_W - LINE_OFF_W - WORD_OFF_W
)
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  cpu_req_t cpu_req_i,
  output cpu_rsp_t cpu_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  logic [NUM_WAYS-1:0]   hit;
  logic [DATA_W-1:0]     word;
  logic [IDX_W-1:0]      rd_idx;
  logic [TAG_W-1:0]      tag;
  logic [NUM_WAYS-1:0]   wr_way;
  logic [IDX_W-1:0]      wr_idx;
  logic                  flush_clr;
  refill_cmd_e           cmd;
  logic [ADDR_W-1:0]     line_adr;
  logic                  beat;
  logic [DATA_W-1:0]     beat_data;
  logic [LINE_OFF_W-1:0] beat_off;
  line_t                 fill_line;
  logic                  done;
  logic                  fill_err;

  icache_ctrl #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cpu_req_i   (cpu_req_i),
    .cpu_rsp_o   (cpu_rsp_o),
    .flush_i     (flush_i),
    .hit_i       (hit),
    .word_i      (word),
    .rd_idx_o    (rd_idx),
    .tag_o       (tag),
    .wr_way_o    (wr_way),
    .wr_idx_o    (wr_idx),
    .flush_clr_o (flush_clr),
    .cmd_o       (cmd),
    .line_adr_o  (line_adr),
    .beat_i      (beat),
    .beat_data_i (beat_data),
    .beat_off_i  (beat_off),
    .done_i      (done),
    .fill_err_i  (fill_err)
  );

  // one tag bus, compare and fill share it
  icache_tag_array #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_tag (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .rd_idx_i  (rd_idx),
    .wr_way_i  (wr_way),
    .wr_idx_i  (wr_idx),
    .wr_tag_i  (tag),
    .flush_i   (flush_clr),
    .cmp_tag_i (tag),
    .hit_o     (hit)
  );

  icache_data_array #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_data (
    .clk_i      (clk_i),
    .rd_idx_i   (rd_idx),
    .wr_way_i   (wr_way),
    .wr_idx_i   (wr_idx),
    .wr_line_i  (fill_line),
    .hit_i      (hit),
    .word_sel_i (cpu_req_i.addr[WORD_OFF_W +: LINE_OFF_W]),
    .word_o     (word)
  );

  icache_refill u_refill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_i       (cmd),
    .line_adr_i  (line_adr),
    .mem_req_o   (mem_req_o),
    .mem_rsp_i   (mem_rsp_i),
    .beat_o      (beat),
    .beat_data_o (beat_data),
    .beat_off_o  (beat_off),
    .line_o      (fill_line),
    .done_o      (done),
    .err_o       (fill_err)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build the icache testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module icache_tb -f files.f -o icache_sim

out=$(./obj_dir/icache_sim 2>&1) || true
printf '%s\n' "$out"

# pass line must be present
printf '%s\n' "$out" | grep -q '^>>> PASS$'
echo "simulation ok"

// ==== sim/icache_checker.sv ====
// protocol assertions for the icache cpu and memory ports
`timescale 1ns/1ps

module icache_checker
  import icache_pkg::*;
(
  input logic     clk_i,
  input logic     rst_ni,
  input cpu_req_t cpu_req_i,
  input cpu_rsp_t cpu_rsp_i,
  input mem_req_t mem_req_i,
  input mem_rsp_t mem_rsp_i
);

  int viol_cnt = 0;  // failed assertions so far

  // ------------------------------------------------------------
  // cpu side
  // ------------------------------------------------------------
  ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cpu_rsp_i.ack && cpu_rsp_i.err))
  else
  begin
    viol_cnt++;
    $error("cpu ack and err high in the same cycle");
  end

  // response only to a live request
  ack_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cpu_rsp_i.ack |-> cpu_req_i.valid)
  else
  begin
    viol_cnt++;
    $error("cpu ack without valid");
  end

  // ------------------------------------------------------------
  // memory side
  // ------------------------------------------------------------
  stb_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_i.stb && !mem_rsp_i.stb_ack) |=> (mem_req_i.stb && $stable(mem_req_i.adr)))
  else
  begin
    viol_cnt++;
    $error("stb or adr dropped before stb_ack");
  end

endmodule

// ==== sim/icache_mem_model.sv ====
// testbench burst memory, random stb_ack and beat delays, error injection
`timescale 1ns/1ps

module icache_mem_model
  import icache_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  mem_req_t          mem_req_i,
  output mem_rsp_t          mem_rsp_o,
  input  int                max_delay_i,  // upper bound of each wait
  input  logic              err_en_i,
  input  logic [ADDR_W-1:0] err_line_i,   // line that answers with err
  output logic              busy_o
);

  localparam int LINE_LSB = LINE_OFF_W + WORD_OFF_W;

  typedef enum logic [1:0] {M_IDLE, M_WAIT, M_ACKED, M_BURST} mem_state_e;

  mem_state_e            state;
  int                    delay;
  logic [LINE_OFF_W-1:0] beat_n;     // beats already sent
  logic [ADDR_W-1:0]     start_adr;  // critical word, wrap starts here
  logic [ADDR_W-1:0]     beat_adr;
  logic                  bad_line;

  assign busy_o   = (state != M_IDLE);
  assign beat_adr = {start_adr[ADDR_W-1:LINE_LSB],
                     LINE_OFF_W'(start_adr[WORD_OFF_W +: LINE_OFF_W] + beat_n),
                     WORD_OFF_W'(0)};
  assign bad_line = err_en_i && (err_line_i[ADDR_W-1:LINE_LSB] == start_adr[ADDR_W-1:LINE_LSB]);

  function automatic int pick_delay(input int max_d);
    return (max_d > 0) ? int'($urandom % (max_d + 1)) : 0;
  endfunction

  always @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state     <= M_IDLE;
      mem_rsp_o <= '0;
      delay     <= 0;
      beat_n    <= '0;
      start_adr <= '0;
    end
    else
    begin
      mem_rsp_o.stb_ack <= 1'b0;  // all strobes single cycle
      mem_rsp_o.ack     <= 1'b0;
      mem_rsp_o.err     <= 1'b0;
      case (state)
        M_IDLE:
        begin
          if (mem_req_i.stb)
          begin
            start_adr <= mem_req_i.adr;
            delay     <= pick_delay(max_delay_i);
            state     <= M_WAIT;
          end
        end
        M_WAIT:
        begin
          if (delay == 0)
          begin
            mem_rsp_o.stb_ack <= 1'b1;
            state             <= M_ACKED;
          end
          else
          begin
            delay <= delay - 1;
          end
        end
        M_ACKED:
        begin
          // burst accepted on this edge
          beat_n <= '0;
          delay  <= pick_delay(max_delay_i);
          state  <= M_BURST;
        end
        default:
        begin
          if (delay != 0)
          begin
            delay <= delay - 1;  // gap between beats
          end
          else
          begin
            mem_rsp_o.adr  <= beat_adr;
            mem_rsp_o.data <= beat_adr ^ 32'h5A5A_0000;
            if (bad_line)
            begin
              mem_rsp_o.err <= 1'b1;  // first beat aborts
              state         <= M_IDLE;
            end
            else
            begin
              mem_rsp_o.ack <= 1'b1;
              beat_n        <= beat_n + 1'b1;
              delay         <= pick_delay(max_delay_i);
              if (beat_n == LINE_OFF_W'(LINE_WORDS - 1))
              begin
                state <= M_IDLE;
              end
            end
          end
        end
      endcase
    end
  end

endmodule

// ==== sim/icache_tb.sv ====
// icache testbench with clock, reset, memory model, directed tests and timeout
`timescale 1ns/1ps

module icache_tb
  import icache_pkg::*;
();

  localparam int NUM_WAYS       = 2;
  localparam int NUM_SETS       = 16;
  localparam int RESET_CYCLES   = 8;
  localparam int MAX_REQS       = 64;   // about 46 fetches over all tests
  localparam int REQ_CYCLES     = 40;   // slowest fill at 3-cycle waits, plus recover
  localparam int TIMEOUT_CYCLES = MAX_REQS * REQ_CYCLES + 200;
  localparam int REQ_TIMEOUT    = 100;  // one fetch, queued behind a fill
  localparam logic [DATA_W-1:0] PATTERN = 32'h5A5A_0000;

  logic              clk = 1'b0;
  logic              rst_n;
  logic              flush;
  cpu_req_t          cpu_req;
  cpu_rsp_t          cpu_rsp;
  mem_req_t          mem_req;
  mem_rsp_t          mem_rsp;
  int                max_delay;
  logic              err_en;
  logic [ADDR_W-1:0] err_line;
  logic              mem_busy;
  int                cycles = 0;
  int                bursts = 0;  // accepted strobes
  int                beats  = 0;  // good beats

  always #2 clk = ~clk;  // 4 ns

  icache_top #(
    .NUM_WAYS (NUM_WAYS),
    .NUM_SETS (NUM_SETS)
  ) u_dut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .flush_i   (flush),
    .cpu_req_i (cpu_req),
    .cpu_rsp_o (cpu_rsp),
    .mem_req_o (mem_req),
    .mem_rsp_i (mem_rsp)
  );

  icache_mem_model u_mem (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .mem_req_i   (mem_req),
    .mem_rsp_o   (mem_rsp),
    .max_delay_i (max_delay),
    .err_en_i    (err_en),
    .err_line_i  (err_line),
    .busy_o      (mem_busy)
  );

  bind icache_top icache_checker u_checker (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .cpu_req_i (cpu_req_i),
    .cpu_rsp_i (cpu_rsp_o),
    .mem_req_i (mem_req_o),
    .mem_rsp_i (mem_rsp_i)
  );

  // ------------------------------------------------------------
  // error exits, bus counters, timeout
  // ------------------------------------------------------------
  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    fail_stop($sformatf("CHECK FAILED t=%0t %s got=%h exp=%h", $time, sig, got, exp));
  endtask

  task automatic check_word(input string sig, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else report_mismatch(sig, got, exp);
  endtask

  // word at A reads as A xor pattern
  function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] addr);
    return {addr[ADDR_W-1:WORD_OFF_W], WORD_OFF_W'(0)} ^ PATTERN;
  endfunction

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (mem_req.stb && mem_rsp.stb_ack)
      begin
        bursts++;
      end
      if (mem_rsp.ack)
      begin
        beats++;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYCLES)
    begin
      fail_stop($sformatf("timeout, tests still running after %0d cycles", cycles));
    end
  end

  // bound checker violations
  always @(posedge clk)
  begin
    if (u_dut.u_checker.viol_cnt != 0)
    begin
      fail_stop("a protocol assertion on the cache ports failed");
    end
  end

  // ------------------------------------------------------------
  // cpu fetch and bus helpers
  // ------------------------------------------------------------
  // lat counts cycles from the first valid cycle to ack or err
  task automatic fetch(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                       output logic got_ack, output logic got_err, output int lat);
    int n;
    n = 0;
    @(posedge clk);
    cpu_req <= '{valid: 1'b1, addr: addr};
    @(negedge clk);
    while (!cpu_rsp.ack && !cpu_rsp.err)
    begin
      n++;
      if (n > REQ_TIMEOUT)
      begin
        fail_stop($sformatf("fetch of %h got neither ack nor err in time", addr));
      end
      @(negedge clk);
    end
    data    = cpu_rsp.data;
    got_ack = cpu_rsp.ack;
    got_err = cpu_rsp.err;
    lat     = n;
    @(posedge clk);   // ack sampled here
    cpu_req <= '0;
  endtask

  task automatic read_check(input logic [ADDR_W-1:0] addr, output int lat);
    logic [DATA_W-1:0] data;
    logic              ack;
    logic              err;
    fetch(addr, data, ack, err, lat);
    check_word("cpu_rsp_o.ack", ack, 32'h1);
    check_word("cpu_rsp_o.err", err, 32'h0);
    check_word("cpu_rsp_o.data", data, mem_word(addr));
  endtask

  // fill finished, then last beat, recover, armed
  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (mem_busy || mem_req.stb)
    begin
      n++;
      if (n > REQ_TIMEOUT)
      begin
        fail_stop("memory stayed busy, the fill never ended");
      end
      @(negedge clk);
    end
    repeat (3) @(posedge clk);
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------
  task automatic cold_miss();
    int b0;
    int k0;
    int lat;
    b0 = bursts;
    k0 = beats;
    read_check(32'h0000_1048, lat);  // set 4, word 2
    wait_idle();
    check_word("burst count", bursts - b0, 32'd1);
    check_word("beat count", beats - k0, LINE_WORDS);
  endtask

  task automatic hit_reads();
    logic [ADDR_W-1:0] addrs [4];
    int                b0;
    int                lat;
    addrs = '{32'h0000_1040, 32'h0000_1044, 32'h0000_104C, 32'h0000_1048};
    b0 = bursts;
    for (int i = 0; i < 4; i++)
    begin
      read_check(addrs[i], lat);
      check_word("cpu_rsp_o.ack latency", lat, 32'd1);
    end
    check_word("burst count", bursts - b0, 32'd0);  // no stb on hits
  endtask

  // three tags in set 4, two ways
  task automatic set_conflict();
    logic [ADDR_W-1:0] lines [3];
    int                b_round1;
    int                lat;
    lines = '{32'h0000_1040, 32'h0000_2044, 32'h0000_3048};
    for (int i = 0; i < 3; i++)
    begin
      read_check(lines[i], lat);
      wait_idle();
    end
    b_round1 = bursts;
    for (int r = 0; r < 3; r++)
    begin
      for (int i = 0; i < 3; i++)
      begin
        read_check(lines[i], lat);
        wait_idle();
      end
    end
    assert (bursts > b_round1)
    else fail_stop("re-reads of three lines in one set never caused a burst");
  endtask

  task automatic flush_refetch();
    int b0;
    int lat;
    read_check(32'h0000_1050, lat);
    wait_idle();
    read_check(32'h0000_1054, lat);
    check_word("cpu_rsp_o.ack latency", lat, 32'd1);  // hit before flush
    b0 = bursts;
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    repeat (3) @(posedge clk);  // flush, recover
    read_check(32'h0000_1054, lat);
    wait_idle();
    check_word("burst count", bursts - b0, 32'd1);
  endtask

  task automatic bus_error_retry();
    logic [DATA_W-1:0] data;
    logic              ack;
    logic              err;
    int                b0;
    int                lat;
    @(posedge clk);
    err_en   <= 1'b1;
    err_line <= 32'h0000_4000;
    b0 = bursts;
    fetch(32'h0000_4004, data, ack, err, lat);
    check_word("cpu_rsp_o.err", err, 32'h1);
    check_word("cpu_rsp_o.ack", ack, 32'h0);
    wait_idle();
    @(posedge clk);
    err_en <= 1'b0;
    read_check(32'h0000_4004, lat);  // line was never validated
    wait_idle();
    check_word("burst count", bursts - b0, 32'd2);
  endtask

  // back to back fetches, next one queued behind the fill
  task automatic back_pressure();
    logic [ADDR_W-1:0] addr;
    int                lat;
    @(posedge clk);
    max_delay <= 3;
    for (int i = 0; i < 24; i++)
    begin
      addr = 32'h0001_0000 | ($urandom & 32'h0000_0FFC);
      read_check(addr, lat);
    end
    wait_idle();
    @(posedge clk);
    max_delay <= 1;
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial
  begin
    void'($urandom(43));
    rst_n     = 1'b0;
    flush     = 1'b0;
    cpu_req   = '0;
    max_delay = 1;
    err_en    = 1'b0;
    err_line  = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    cold_miss();
    hit_reads();
    set_conflict();
    flush_refetch();
    bus_error_retry();
    back_pressure();

    if (u_dut.u_checker.viol_cnt == 0)
    begin
      $display(">>> PASS");
      $finish;
    end
    else
    begin
      fail_stop("protocol assertions failed during the run");
    end
  end

endmodule
